// File: Bender.yml
package:
  name: mcpu_mem

sources:
  - include_dirs:
      - hw
    files:
      - hw/mcpu_core_pkg.sv
      - hw/mcpu_dcache_pkg.sv
      - hw/mcpu_core_stage_mem.sv
      - hw/mcpu_dcache_ctrl.sv
      - hw/mcpu_dcache_fill_counter.sv
      - hw/mcpu_dcache_array.sv
      - hw/mcpu_mem_top.sv
  - target: test
    files:
      - bench/mcpu_mem_wb_mem.sv
      - bench/mcpu_mem_chk.sv
      - bench/mcpu_mem_tb.sv

// File: bench/mcpu_mem_chk.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_mem_chk (
  input  logic                       clkrst_core_clk,
  input  logic                       clkrst_core_rst_n,
  input  mcpu_dcache_pkg::dc_state_t state_q,
  input  logic                       req_done,
  input  logic                       hit,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [29:0]                wb_adr,
  input  logic [3:0]                 wb_sel,
  input  logic [31:0]                wb_dat_w,
  input  logic                       wb_ack
);
  import mcpu_dcache_pkg::*;

  int unsigned fail_count = 0;  // read by the testbench at the end

  // one idle cycle between beats
  cyc_stb_drop_after_ack: assert property (@(posedge clkrst_core_clk)
    disable iff (!clkrst_core_rst_n)
    (wb_stb && wb_ack) |=> !wb_cyc && !wb_stb)
    else begin
      $error("wb_cyc or wb_stb still high in the cycle after an ack");
      fail_count++;
    end

  // master holds the beat until the slave acks
  wb_stable_until_ack: assert property (@(posedge clkrst_core_clk)
    disable iff (!clkrst_core_rst_n)
    (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_we) && $stable(wb_adr) &&
                            $stable(wb_sel) && $stable(wb_dat_w))
    else begin
      $error("Wishbone master outputs changed before ack");
      fail_count++;
    end

  // done comes back only once memory has answered
  done_after_ack: assert property (@(posedge clkrst_core_clk)
    disable iff (!clkrst_core_rst_n)
    $rose(req_done) |-> $past(wb_ack))
    else begin
      $error("req_done rose without a Wishbone ack in the cycle before");
      fail_count++;
    end

  fill_ends_in_hit: assert property (@(posedge clkrst_core_clk)
    disable iff (!clkrst_core_rst_n)
    ((state_q == DC_LOOKUP) && ($past(state_q) == DC_FILL)) |-> hit && req_done)
    else begin
      $error("lookup after a line fill did not complete as a hit");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: bench/mcpu_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_mem_tb;
  import mcpu_core_pkg::*;

  localparam int N_RANDOM   = 300;
  localparam int N_DIRECTED = 40;
  localparam int MAX_CYCLES = 40 * (N_RANDOM + N_DIRECTED) + 100;

  logic        clkrst_core_clk;
  logic        clkrst_core_rst_n;
  logic        mem_valid_in;
  logic        mem_out_ok;
  logic        mem_ready_in;
  logic        mem_ready_out;
  logic        mem_valid_out;
  logic [31:0] pc2mem_in_paddr;
  logic [31:0] pc2mem_in_data;
  mem_op_t     pc2mem_in_type;
  logic [4:0]  pc2mem_in_rd_num;
  logic        pc2mem_in_rd_we;
  logic [31:0] mem2wb_out_data;
  logic [4:0]  mem2wb_out_rd_num;
  logic        mem2wb_out_rd_we;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [29:0] wb_adr;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  logic [31:0] shadow [1024];
  logic [38:0] expect_q [$];  // {is_load, rd_we, rd_num, data}
  logic [38:0] expect_entry;
  logic [3:0]  store_sel;
  int          errors;
  int          errors_before;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  int          issued;
  int          results;
  int          wb_reads;
  int          wb_writes;

  mcpu_mem_top i_mcpu_mem_top (.*);

  mcpu_mem_wb_mem i_wb_mem (.*);

  bind mcpu_dcache_ctrl mcpu_mem_chk i_chk (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .state_q           (state_q),
    .req_done          (req_done),
    .hit               (hit),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_adr            (wb_adr),
    .wb_sel            (wb_sel),
    .wb_dat_w          (wb_dat_w),
    .wb_ack            (wb_ack)
  );

  initial clkrst_core_clk = 1'b0;
  always #5 clkrst_core_clk = ~clkrst_core_clk;

  always @(posedge clkrst_core_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // expected byte lanes of a store
  function automatic logic [3:0] lane_mask(mem_op_t op, logic [31:0] addr);
    case (op)
      MEM_SW:  return 4'b1111;
      MEM_SH:  return addr[1] ? 4'b1100 : 4'b0011;
      MEM_SB:  return 4'b0001 << addr[1:0];
      default: return 4'b0000;
    endcase
  endfunction

  // updates the shadow for stores, returns load data zero-extended
  function automatic logic [31:0] model_access(mem_op_t op, logic [31:0] addr,
                                               logic [31:0] data);
    logic [9:0]  w;
    logic [31:0] word;
    w    = addr[11:2];
    word = shadow[w];
    case (op)
      MEM_SW:  shadow[w] = data;
      MEM_SH:  shadow[w][16*addr[1] +: 16] = data[15:0];
      MEM_SB:  shadow[w][8*addr[1:0] +: 8] = data[7:0];
      MEM_LW:  return word;
      MEM_LH:  return {16'h0000, word[16*addr[1] +: 16]};
      default: return {24'h000000, word[8*addr[1:0] +: 8]};
    endcase
    return 32'h0;
  endfunction

  task automatic report_mismatch(string sig, logic [31:0] expected, logic [31:0] actual);
    $display("ERR %s expected %h actual %h", sig, expected, actual);
    errors++;
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %-28s ok", name);
    end else begin
      tests_failed++;
      $display("test %-28s %0d errors", name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic issue(mem_op_t op, logic [31:0] addr, logic [31:0] data, logic [4:0] rd,
                       logic rd_we);
    logic [31:0] expected;
    mem_valid_in     = 1'b1;
    pc2mem_in_type   = op;
    pc2mem_in_paddr  = addr;
    pc2mem_in_data   = data;
    pc2mem_in_rd_num = rd;
    pc2mem_in_rd_we  = rd_we;
    #1;
    while (!mem_ready_in) begin
      @(negedge clkrst_core_clk);
      #1;
    end
    if (op[2]) store_sel = lane_mask(op, addr);
    expected = model_access(op, addr, data);
    expect_q.push_back({~op[2], rd_we, rd, expected});
    issued++;
    @(negedge clkrst_core_clk);
    mem_valid_in = 1'b0;
  endtask

  task automatic drain();
    while (expect_q.size() != 0) begin
      @(negedge clkrst_core_clk);
    end
  endtask

  // compare process, outputs are registered so the falling edge is stable
  always @(negedge clkrst_core_clk) begin
    if (clkrst_core_rst_n) begin
      if (wb_cyc && mem_ready_out !== 1'b0) begin
        report_mismatch("mem_ready_out", 32'h0, mem_ready_out);  // cache busy on the bus
      end
      if (wb_cyc && wb_ack) begin
        if (wb_we) begin
          wb_writes++;
          if (wb_sel !== store_sel) report_mismatch("wb_sel", store_sel, wb_sel);
        end else begin
          wb_reads++;
        end
      end
      if (mem_valid_out) begin
        if (expect_q.size() == 0) begin
          $display("a result appeared with no accepted operation waiting for it");
          errors++;
        end else begin
          expect_entry = expect_q.pop_front();
          results++;
          if (expect_entry[38] && mem2wb_out_data !== expect_entry[31:0]) begin
            report_mismatch("mem2wb_out_data", expect_entry[31:0], mem2wb_out_data);
          end
          if (mem2wb_out_rd_num !== expect_entry[36:32]) begin
            report_mismatch("mem2wb_out_rd_num", expect_entry[36:32], mem2wb_out_rd_num);
          end
          if (mem2wb_out_rd_we !== expect_entry[37]) begin
            report_mismatch("mem2wb_out_rd_we", expect_entry[37], mem2wb_out_rd_we);
          end
        end
      end
    end
  end

  initial begin
    mem_op_t     op;
    logic [31:0] addr;
    void'($urandom(32'h94d3));
    clkrst_core_rst_n = 1'b0;
    mem_valid_in      = 1'b0;
    mem_out_ok        = 1'b1;
    pc2mem_in_paddr   = 32'h0;
    pc2mem_in_data    = 32'h0;
    pc2mem_in_type    = MEM_LB;
    pc2mem_in_rd_num  = 5'd0;
    pc2mem_in_rd_we   = 1'b0;
    store_sel         = 4'b0000;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = i ^ 32'h5a5a_0000;
    end
    repeat (3) @(negedge clkrst_core_clk);
    clkrst_core_rst_n = 1'b1;
    @(negedge clkrst_core_clk);
    if (mem_valid_out !== 1'b0) report_mismatch("mem_valid_out", 32'h0, mem_valid_out);
    if (wb_cyc !== 1'b0) report_mismatch("wb_cyc", 32'h0, wb_cyc);
    if (wb_stb !== 1'b0) report_mismatch("wb_stb", 32'h0, wb_stb);
    if (mem_ready_in !== 1'b1) report_mismatch("mem_ready_in", 32'h1, mem_ready_in);
    if (mem_ready_out !== 1'b1) report_mismatch("mem_ready_out", 32'h1, mem_ready_out);
    finish_test("reset state");

    issue(MEM_SW, 32'h0000_0100, 32'hcafe_f00d, 5'd1, 1'b0);
    issue(MEM_LW, 32'h0000_0100, 32'h0, 5'd2, 1'b1);
    drain();
    if (i_wb_mem.mem[64] !== 32'hcafe_f00d) begin
      report_mismatch("i_wb_mem.mem[64]", 32'hcafe_f00d, i_wb_mem.mem[64]);
    end
    finish_test("word store then load");

    for (int off = 0; off < 4; off++) begin
      issue(MEM_LB, 32'h200 + off, 32'h0, 5'd3, 1'b1);  // untouched pattern
      issue(MEM_SB, 32'h200 + off, $urandom, 5'd4, 1'b0);
      issue(MEM_LB, 32'h200 + off, 32'h0, 5'd5, 1'b1);
    end
    issue(MEM_LW, 32'h200, 32'h0, 5'd6, 1'b1);
    for (int off = 0; off < 4; off += 2) begin
      issue(MEM_LH, 32'h210 + off, 32'h0, 5'd7, 1'b1);
      issue(MEM_SH, 32'h210 + off, $urandom, 5'd8, 1'b0);
      issue(MEM_LH, 32'h210 + off, 32'h0, 5'd9, 1'b1);
    end
    issue(MEM_LW, 32'h210, 32'h0, 5'd10, 1'b1);
    drain();
    finish_test("byte and halfword lanes");

    for (int i = 0; i < N_RANDOM; i++) begin
      addr       = $urandom_range(511, 0) << 2;
      addr[1:0]  = $urandom_range(3, 0);
      case ($urandom_range(5, 0))
        0:       op = MEM_LB;
        1:       op = MEM_LH;
        2:       op = MEM_LW;
        3:       op = MEM_SB;
        4:       op = MEM_SH;
        default: op = MEM_SW;
      endcase
      if (op[1]) addr[1:0] = 2'b00;  // keep accesses aligned
      else if (op[0]) addr[0] = 1'b0;
      issue(op, addr, $urandom, $urandom_range(31, 0), $urandom_range(1, 0));
    end
    drain();
    finish_test("random operations");

    // line outside the random range, so a wrongly issued load would miss
    mem_out_ok       = 1'b0;
    mem_valid_in     = 1'b1;
    pc2mem_in_type   = MEM_LW;
    pc2mem_in_paddr  = 32'hc00;
    pc2mem_in_rd_num = 5'd11;
    pc2mem_in_rd_we  = 1'b1;
    repeat (8) begin
      #1;
      if (mem_ready_in !== 1'b0) report_mismatch("mem_ready_in", 32'h0, mem_ready_in);
      if (wb_cyc !== 1'b0) report_mismatch("wb_cyc", 32'h0, wb_cyc);
      @(negedge clkrst_core_clk);
    end
    mem_out_ok = 1'b1;
    issue(MEM_LW, 32'hc00, 32'h0, 5'd11, 1'b1);
    issue(MEM_SW, 32'hc04, 32'h1234_5678, 5'd12, 1'b0);
    issue(MEM_LW, 32'hc04, 32'h0, 5'd13, 1'b1);
    drain();
    if (results != issued) begin
      $display("%0d results seen for %0d accepted operations", results, issued);
      errors++;
    end
    finish_test("back-pressure");

    wb_reads  = 0;
    wb_writes = 0;
    issue(MEM_LW, 32'h800, 32'h0, 5'd14, 1'b1);
    drain();
    if (wb_reads != 4) begin
      $display("first load of the line made %0d read beats instead of 4", wb_reads);
      errors++;
    end
    wb_reads = 0;
    issue(MEM_LW, 32'h804, 32'h0, 5'd15, 1'b1);
    issue(MEM_LW, 32'h80c, 32'h0, 5'd16, 1'b1);
    issue(MEM_SW, 32'h808, 32'ha5a5_0f0f, 5'd17, 1'b0);
    issue(MEM_LW, 32'h808, 32'h0, 5'd18, 1'b1);
    drain();
    if (wb_reads != 0 || wb_writes != 1) begin
      $display("cached line saw %0d reads and %0d writes, expected 0 and 1",
               wb_reads, wb_writes);
      errors++;
    end
    finish_test("line fill and store hit");

    if (i_mcpu_mem_top.i_dcache_ctrl.i_chk.fail_count != 0) begin
      $display("%0d assertion failures in the cache controller",
               i_mcpu_mem_top.i_dcache_ctrl.i_chk.fail_count);
      errors += i_mcpu_mem_top.i_dcache_ctrl.i_chk.fail_count;
    end

    $display("%0d tests, %0d failed, %0d errors, %0d of %0d results checked",
             tests_run, tests_failed, errors, results, issued);
    if (errors == 0 && results == issued) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/mcpu_mem_wb_mem.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_mem_wb_mem (
  input  logic        clkrst_core_clk,
  input  logic        clkrst_core_rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [29:0] wb_adr,
  input  logic [3:0]  wb_sel,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic [31:0] mem [1024];
  logic [1:0]  wait_left;
  logic        busy;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = i ^ 32'h5a5a_0000;  // pattern from the word address
    end
  end

  // registered ack, 0 to 3 wait cycles drawn per beat
  always @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      wb_ack    <= 1'b0;
      wb_dat_r  <= 32'h0;
      busy      <= 1'b0;
      wait_left <= 2'd0;
    end else begin
      wb_ack <= 1'b0;
      if (wb_cyc && wb_stb && !wb_ack) begin
        if (!busy) begin
          busy      <= 1'b1;  // new beat
          wait_left <= $urandom_range(3, 0);
        end else if (wait_left != 0) begin
          wait_left <= wait_left - 1'b1;
        end else begin
          busy   <= 1'b0;
          wb_ack <= 1'b1;
          if (wb_we) begin
            for (int b = 0; b < 4; b++) begin
              if (wb_sel[b]) mem[wb_adr[9:0]][8*b +: 8] = wb_dat_w[8*b +: 8];
            end
          end else begin
            wb_dat_r <= mem[wb_adr[9:0]];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/mcpu_core_pkg.sv
`default_nettype none

package mcpu_core_pkg;

  // memory operation from the previous pipeline stage
  // bit 2 store, bit 1 word, bit 0 halfword
  typedef enum logic [2:0] {
    MEM_LB = 3'b000,  // load byte, zero-extended
    MEM_LH = 3'b001,  // load halfword, zero-extended
    MEM_LW = 3'b010,
    MEM_SB = 3'b100,
    MEM_SH = 3'b101,
    MEM_SW = 3'b110
  } mem_op_t;

endpackage

`default_nettype wire

// File: hw/mcpu_core_stage_mem.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_core_stage_mem (
  input  logic                   clkrst_core_clk,
  input  logic                   clkrst_core_rst_n,
  input  logic                   mem_valid_in,
  input  logic                   mem_out_ok,
  output logic                   mem_ready_in,
  output logic                   mem_ready_out,
  output logic                   mem_valid_out,
  input  logic [31:0]            pc2mem_in_paddr,
  input  logic [31:0]            pc2mem_in_data,
  input  mcpu_core_pkg::mem_op_t pc2mem_in_type,
  input  logic [4:0]             pc2mem_in_rd_num,
  input  logic                   pc2mem_in_rd_we,
  output logic [31:0]            mem2wb_out_data,
  output logic [4:0]             mem2wb_out_rd_num,
  output logic                   mem2wb_out_rd_we,
  output logic [29:0]            mem2dc_paddr,
  output logic [3:0]             mem2dc_write,
  output logic                   mem2dc_valid,
  input  logic                   mem2dc_done,
  input  logic [31:0]            mem2dc_data_in,
  output logic [31:0]            mem2dc_data_out
);
  import mcpu_core_pkg::*;

  logic       mem_inprogress;
  mem_op_t    type_q;
  logic [1:0] addr_lo_q;
  logic [4:0] rd_num_q;
  logic       rd_we_q;

  // byte mask and lane placement, mask stays zero for loads
  always_comb begin
    mem2dc_data_out = pc2mem_in_data;
    case (pc2mem_in_type)
      MEM_SW: mem2dc_write = 4'b1111;
      MEM_SH: begin
        mem2dc_write    = 4'b0011 << {pc2mem_in_paddr[1], 1'b0};
        mem2dc_data_out = pc2mem_in_data << {pc2mem_in_paddr[1], 4'b0000};
      end
      MEM_SB: begin
        mem2dc_write    = 4'b0001 << pc2mem_in_paddr[1:0];
        mem2dc_data_out = pc2mem_in_data << {pc2mem_in_paddr[1:0], 3'b000};
      end
      default: mem2dc_write = 4'b0000;  // any load
    endcase
  end

  assign mem2dc_paddr = pc2mem_in_paddr[31:2];
  assign mem2dc_valid = mem_valid_in & mem_out_ok;

  // flag only set for a request the cache actually took
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      mem_inprogress <= 1'b0;
    end else if (mem2dc_done) begin
      mem_inprogress <= mem2dc_valid;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (mem2dc_done) begin
      type_q    <= pc2mem_in_type;
      addr_lo_q <= pc2mem_in_paddr[1:0];
      rd_num_q  <= pc2mem_in_rd_num;
      rd_we_q   <= pc2mem_in_rd_we;
    end
  end

  // shift the wanted lane down, masking gives zero extension
  always_comb begin
    case (type_q)
      MEM_LW, MEM_SW: mem2wb_out_data = mem2dc_data_in;
      MEM_LH, MEM_SH: mem2wb_out_data = (mem2dc_data_in >> {addr_lo_q[1], 4'b0000}) & 32'h0000_ffff;
      default:        mem2wb_out_data = (mem2dc_data_in >> {addr_lo_q, 3'b000}) & 32'h0000_00ff;
    endcase
  end

  assign mem2wb_out_rd_num = rd_num_q;
  assign mem2wb_out_rd_we  = rd_we_q;

  assign mem_valid_out = mem2dc_done & mem_inprogress;
  assign mem_ready_out = mem2dc_done;
  assign mem_ready_in  = ~mem_valid_in | (mem_out_ok & mem_ready_out);

endmodule

`default_nettype wire

// File: hw/mcpu_dcache_array.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_dcache_array (
  input  logic                        clkrst_core_clk,
  input  logic                        clkrst_core_rst_n,
  input  mcpu_dcache_pkg::dc_index_t  arr_index,
  input  mcpu_dcache_pkg::dc_tag_t    arr_tag,
  input  mcpu_dcache_pkg::dc_offset_t arr_offset,
  input  logic                        arr_we,
  input  logic                        arr_fill,
  input  logic [3:0]                  arr_wmask,
  input  logic [31:0]                 arr_wdata,
  output logic                        hit,
  output logic [31:0]                 rd_data
);
  import mcpu_dcache_pkg::*;

  dc_tag_t                           tag_mem [DC_LINES];
  logic [DC_LINES-1:0]               valid_q;
  logic [31:0]                       data_mem [DC_LINES * DC_WORDS];
  logic [DC_INDEX_W+DC_OFFSET_W-1:0] word_sel;
  logic                              last_beat;

  assign word_sel  = {arr_index, arr_offset};
  assign last_beat = &arr_offset;

  // combinational lookup
  assign hit     = valid_q[arr_index] && (tag_mem[arr_index] == arr_tag);
  assign rd_data = data_mem[word_sel];

  always_ff @(posedge clkrst_core_clk) begin
    if (arr_we) begin
      for (int b = 0; b < 4; b++) begin
        if (arr_wmask[b]) begin
          data_mem[word_sel][8*b +: 8] <= arr_wdata[8*b +: 8];
        end
      end
      if (arr_fill && last_beat) begin
        tag_mem[arr_index] <= arr_tag;  // tag lands with the last word
      end
    end
  end

  // line is invalid while a fill is partway through
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      valid_q <= '0;
    end else if (arr_we && arr_fill) begin
      valid_q[arr_index] <= last_beat;
    end
  end

endmodule

`default_nettype wire

// File: hw/mcpu_dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_dcache_ctrl (
  input  logic                        clkrst_core_clk,
  input  logic                        clkrst_core_rst_n,
  input  logic                        req_valid,
  input  logic [29:0]                 req_addr,
  input  logic [3:0]                  req_write,
  input  logic [31:0]                 req_data,
  output logic                        req_done,
  output logic [31:0]                 req_rdata,
  input  logic                        hit,
  input  logic [31:0]                 rd_data,
  output mcpu_dcache_pkg::dc_index_t  arr_index,
  output mcpu_dcache_pkg::dc_tag_t    arr_tag,
  output logic                        arr_we,
  output logic                        arr_fill,
  output mcpu_dcache_pkg::dc_offset_t arr_offset,
  output logic [3:0]                  arr_wmask,
  output logic [31:0]                 arr_wdata,
  input  mcpu_dcache_pkg::dc_offset_t beat,
  input  logic                        beat_last,
  output logic                        cnt_clear,
  output logic                        cnt_step,
  output logic                        wb_cyc,
  output logic                        wb_stb,
  output logic                        wb_we,
  output logic [29:0]                 wb_adr,
  output logic [3:0]                  wb_sel,
  output logic [31:0]                 wb_dat_w,
  input  logic [31:0]                 wb_dat_r,
  input  logic                        wb_ack
);
  import mcpu_dcache_pkg::*;

  dc_state_t   state_q;
  dc_state_t   state_d;
  logic [29:0] addr_q;
  logic [3:0]  wmask_q;
  logic [31:0] wdata_q;
  logic        gap_q;  // idle cycle after each ack
  logic        is_store;

  assign is_store = |wmask_q;

  assign arr_index  = addr_q[DC_OFFSET_W +: DC_INDEX_W];
  assign arr_tag    = addr_q[29 -: DC_TAG_W];
  assign arr_offset = (state_q == DC_FILL) ? beat : addr_q[DC_OFFSET_W-1:0];

  // idle, or a load hit finishing this cycle
  assign req_done  = (state_q == DC_IDLE) ||
                     ((state_q == DC_LOOKUP) && hit && !is_store);
  assign req_rdata = rd_data;

  always_comb begin
    state_d   = state_q;
    arr_we    = 1'b0;
    arr_fill  = 1'b0;
    arr_wmask = wmask_q;
    arr_wdata = wdata_q;
    cnt_clear = 1'b0;
    cnt_step  = 1'b0;
    case (state_q)
      DC_IDLE: begin
        if (req_valid) state_d = DC_LOOKUP;
      end
      DC_LOOKUP: begin
        if (is_store) begin
          arr_we  = hit;  // no allocate on a store miss
          state_d = DC_WRITE;
        end else if (hit) begin
          state_d = req_valid ? DC_LOOKUP : DC_IDLE;  // back-to-back hits
        end else begin
          cnt_clear = 1'b1;
          state_d   = DC_FILL;
        end
      end
      DC_FILL: begin
        arr_wmask = 4'b1111;
        arr_wdata = wb_dat_r;
        if (wb_stb && wb_ack) begin
          arr_we   = 1'b1;
          arr_fill = 1'b1;
          cnt_step = 1'b1;
          if (beat_last) state_d = DC_LOOKUP;  // retry, hits now
        end
      end
      DC_WRITE: begin
        if (wb_stb && wb_ack) state_d = DC_IDLE;
      end
      default: state_d = DC_IDLE;
    endcase
  end

  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      state_q <= DC_IDLE;
      gap_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      gap_q   <= wb_stb & wb_ack;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (req_valid && req_done) begin
      addr_q  <= req_addr;
      wmask_q <= req_write;
      wdata_q <= req_data;
    end
  end

  // outputs only move on an ack, so they hold for the whole beat
  assign wb_cyc   = ((state_q == DC_FILL) || (state_q == DC_WRITE)) && !gap_q;
  assign wb_stb   = wb_cyc;
  assign wb_we    = (state_q == DC_WRITE);
  assign wb_adr   = {arr_tag, arr_index, arr_offset};
  assign wb_sel   = (state_q == DC_WRITE) ? wmask_q : 4'b1111;
  assign wb_dat_w = wdata_q;

endmodule

`default_nettype wire

// File: hw/mcpu_dcache_fill_counter.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_dcache_fill_counter (
  input  logic                        clkrst_core_clk,
  input  logic                        clkrst_core_rst_n,
  input  logic                        cnt_clear,
  input  logic                        cnt_step,
  output mcpu_dcache_pkg::dc_offset_t beat,
  output logic                        beat_last
);
  import mcpu_dcache_pkg::*;

  dc_offset_t cnt_q;

  // clear wins over step
  always_ff @(posedge clkrst_core_clk or negedge clkrst_core_rst_n) begin
    if (!clkrst_core_rst_n) begin
      cnt_q <= '0;
    end else if (cnt_clear) begin
      cnt_q <= '0;
    end else if (cnt_step) begin
      cnt_q <= cnt_q + 1'b1;  // wraps after the last word
    end
  end

  assign beat      = cnt_q;
  assign beat_last = &cnt_q;  // final word of the line

endmodule

`default_nettype wire

// File: hw/mcpu_dcache_pkg.sv
`default_nettype none

`include "mcpu_mem_settings.svh"

package mcpu_dcache_pkg;

  localparam int unsigned DC_INDEX_W  = `MCPU_DC_INDEX_BITS;
  localparam int unsigned DC_OFFSET_W = `MCPU_DC_OFFSET_BITS;
  localparam int unsigned DC_TAG_W    = 30 - DC_INDEX_W - DC_OFFSET_W;  // word address split
  localparam int unsigned DC_LINES    = 1 << DC_INDEX_W;
  localparam int unsigned DC_WORDS    = 1 << DC_OFFSET_W;  // words per line

  typedef logic [DC_INDEX_W-1:0]  dc_index_t;
  typedef logic [DC_OFFSET_W-1:0] dc_offset_t;
  typedef logic [DC_TAG_W-1:0]    dc_tag_t;

  typedef enum logic [1:0] {
    DC_IDLE,
    DC_LOOKUP,  // tag compare on the latched request
    DC_FILL,
    DC_WRITE    // write-through beat
  } dc_state_t;

endpackage

`default_nettype wire

// File: hw/mcpu_mem_settings.svh
`ifndef MCPU_MEM_SETTINGS_SVH
`define MCPU_MEM_SETTINGS_SVH

// data cache geometry, 16 lines of 4 words
`define MCPU_DC_INDEX_BITS 4  // log2 of line count
`define MCPU_DC_OFFSET_BITS 2  // log2 of words per line

`endif

// File: hw/mcpu_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module mcpu_mem_top (
  input  logic                   clkrst_core_clk,
  input  logic                   clkrst_core_rst_n,
  input  logic                   mem_valid_in,
  input  logic                   mem_out_ok,
  output logic                   mem_ready_in,
  output logic                   mem_ready_out,
  output logic                   mem_valid_out,
  input  logic [31:0]            pc2mem_in_paddr,
  input  logic [31:0]            pc2mem_in_data,
  input  mcpu_core_pkg::mem_op_t pc2mem_in_type,
  input  logic [4:0]             pc2mem_in_rd_num,
  input  logic                   pc2mem_in_rd_we,
  output logic [31:0]            mem2wb_out_data,
  output logic [4:0]             mem2wb_out_rd_num,
  output logic                   mem2wb_out_rd_we,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [29:0]            wb_adr,
  output logic [3:0]             wb_sel,
  output logic [31:0]            wb_dat_w,
  input  logic [31:0]            wb_dat_r,
  input  logic                   wb_ack
);
  import mcpu_dcache_pkg::*;

  // stage to cache
  logic        mem2dc_valid;
  logic [29:0] mem2dc_paddr;
  logic [3:0]  mem2dc_write;
  logic [31:0] mem2dc_data_out;
  logic        mem2dc_done;
  logic [31:0] mem2dc_data_in;

  // controller to storage and beat counter
  dc_index_t   arr_index;
  dc_tag_t     arr_tag;
  dc_offset_t  arr_offset;
  logic        arr_we;
  logic        arr_fill;
  logic [3:0]  arr_wmask;
  logic [31:0] arr_wdata;
  logic        hit;
  logic [31:0] rd_data;
  dc_offset_t  beat;
  logic        beat_last;
  logic        cnt_clear;
  logic        cnt_step;

  mcpu_core_stage_mem i_stage_mem (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .mem_valid_in      (mem_valid_in),
    .mem_out_ok        (mem_out_ok),
    .mem_ready_in      (mem_ready_in),
    .mem_ready_out     (mem_ready_out),
    .mem_valid_out     (mem_valid_out),
    .pc2mem_in_paddr   (pc2mem_in_paddr),
    .pc2mem_in_data    (pc2mem_in_data),
    .pc2mem_in_type    (pc2mem_in_type),
    .pc2mem_in_rd_num  (pc2mem_in_rd_num),
    .pc2mem_in_rd_we   (pc2mem_in_rd_we),
    .mem2wb_out_data   (mem2wb_out_data),
    .mem2wb_out_rd_num (mem2wb_out_rd_num),
    .mem2wb_out_rd_we  (mem2wb_out_rd_we),
    .mem2dc_paddr      (mem2dc_paddr),
    .mem2dc_write      (mem2dc_write),
    .mem2dc_valid      (mem2dc_valid),
    .mem2dc_done       (mem2dc_done),
    .mem2dc_data_in    (mem2dc_data_in),
    .mem2dc_data_out   (mem2dc_data_out)
  );

  mcpu_dcache_ctrl i_dcache_ctrl (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .req_valid         (mem2dc_valid),
    .req_addr          (mem2dc_paddr),
    .req_write         (mem2dc_write),
    .req_data          (mem2dc_data_out),
    .req_done          (mem2dc_done),
    .req_rdata         (mem2dc_data_in),
    .hit               (hit),
    .rd_data           (rd_data),
    .arr_index         (arr_index),
    .arr_tag           (arr_tag),
    .arr_we            (arr_we),
    .arr_fill          (arr_fill),
    .arr_offset        (arr_offset),
    .arr_wmask         (arr_wmask),
    .arr_wdata         (arr_wdata),
    .beat              (beat),
    .beat_last         (beat_last),
    .cnt_clear         (cnt_clear),
    .cnt_step          (cnt_step),
    .wb_cyc            (wb_cyc),
    .wb_stb            (wb_stb),
    .wb_we             (wb_we),
    .wb_adr            (wb_adr),
    .wb_sel            (wb_sel),
    .wb_dat_w          (wb_dat_w),
    .wb_dat_r          (wb_dat_r),
    .wb_ack            (wb_ack)
  );

  mcpu_dcache_fill_counter i_fill_counter (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .cnt_clear         (cnt_clear),
    .cnt_step          (cnt_step),
    .beat              (beat),
    .beat_last         (beat_last)
  );

  mcpu_dcache_array i_dcache_array (
    .clkrst_core_clk   (clkrst_core_clk),
    .clkrst_core_rst_n (clkrst_core_rst_n),
    .arr_index         (arr_index),
    .arr_tag           (arr_tag),
    .arr_offset        (arr_offset),
    .arr_we            (arr_we),
    .arr_fill          (arr_fill),
    .arr_wmask         (arr_wmask),
    .arr_wdata         (arr_wdata),
    .hit               (hit),
    .rd_data           (rd_data)
  );

endmodule

`default_nettype wire

// File: mcpu_mem.f
+incdir+hw
hw/mcpu_core_pkg.sv
hw/mcpu_dcache_pkg.sv
hw/mcpu_core_stage_mem.sv
hw/mcpu_dcache_ctrl.sv
hw/mcpu_dcache_fill_counter.sv
hw/mcpu_dcache_array.sv
hw/mcpu_mem_top.sv
bench/mcpu_mem_wb_mem.sv
bench/mcpu_mem_chk.sv
bench/mcpu_mem_tb.sv
